// File: Makefile
# Verilator build and run of the intersection testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
		--top-module intersection_tb -Mdir obj_dir
	./obj_dir/Vintersection_tb | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: hw/beam_decoder.sv
module beam_decoder (
	input  logic dclk,
	input  logic clr,
	beam_if.source beam
);

	// horizontal and vertical raster counters
	vga_timing_pkg::coord_t hc;
	vga_timing_pkg::coord_t vc;

	// ------------------------------------------------------------------------
	// raster counters
	// ------------------------------------------------------------------------
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			hc <= '0;
			vc <= '0;
		end
		else if (hc == vga_timing_pkg::H_TOTAL - 10'd1)
		begin
			// end of line, step to next line
			hc <= '0;
			if (vc == vga_timing_pkg::V_TOTAL - 10'd1)
				vc <= '0;
			else
				vc <= vc + 10'd1;
		end
		else
		begin
			hc <= hc + 10'd1;
		end
	end

	// ------------------------------------------------------------------------
	// decode, combinational from the counters
	// ------------------------------------------------------------------------
	// sync low at start of line / frame
	assign beam.hsync_n = (hc >= vga_timing_pkg::H_PULSE);
	assign beam.vsync_n = (vc >= vga_timing_pkg::V_PULSE);

	// visible window between the porches
	assign beam.active = (hc >= vga_timing_pkg::H_BP) && (hc < vga_timing_pkg::H_FP) &&
		(vc >= vga_timing_pkg::V_BP) && (vc < vga_timing_pkg::V_FP);

	// screen coordinates
	// outside the window these wrap and are ignored
	assign beam.px = hc - vga_timing_pkg::H_BP;
	assign beam.py = vc - vga_timing_pkg::V_BP;

endmodule

// File: hw/collision_detector.sv
module collision_detector (
	input  logic    dclk,
	input  logic    clr,
	car_if.detector cars
);

	// any crossing pair overlaps this cycle
	logic overlap;

	// closed interval test on one axis
	// shared edge counts as a hit
	function automatic logic span_touch(
		input vga_timing_pkg::coord_t a0,
		input vga_timing_pkg::coord_t a_len,
		input vga_timing_pkg::coord_t b0,
		input vga_timing_pkg::coord_t b_len
	);
		return ({1'b0, a0} <= ({1'b0, b0} + {1'b0, b_len})) &&
			({1'b0, b0} <= ({1'b0, a0} + {1'b0, a_len}));
	endfunction

	// ------------------------------------------------------------------------
	// pairwise test, eastbound car i against southbound car j
	// ------------------------------------------------------------------------
	always_comb
	begin
		overlap = 1'b0;
		for (int i = 0; i < scene_pkg::NUM_CARS; i++)
		begin
			for (int j = 0; j < scene_pkg::NUM_CARS; j++)
			begin
				// same-lane pairs are never tested
				if ((scene_pkg::CAR_DIR[i] == scene_pkg::DIR_EAST) &&
					(scene_pkg::CAR_DIR[j] == scene_pkg::DIR_SOUTH))
				begin
					if (span_touch(scene_pkg::car_x(i, cars.offset[i]), scene_pkg::car_w(i),
						scene_pkg::car_x(j, cars.offset[j]), scene_pkg::car_w(j)) &&
						span_touch(scene_pkg::car_y(i, cars.offset[i]), scene_pkg::car_h(i),
						scene_pkg::car_y(j, cars.offset[j]), scene_pkg::car_h(j)))
						overlap = 1'b1;
				end
			end
		end
	end

	// sticky until clr
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
			cars.crashed <= 1'b0;
		else if (overlap)
			cars.crashed <= 1'b1;
	end

endmodule

// File: hw/intersection_top.sv
module intersection_top (
	input  logic       dclk,
	input  logic       clr,
	input  logic       anim_tick,
	input  logic [3:0] light,
	output logic       hsync,
	output logic       vsync,
	output logic [2:0] red,
	output logic [2:0] green,
	output logic [1:0] blue,
	output logic       game_over
);

	// registered pixel from the compositor
	scene_pkg::rgb_t pix_rgb;

	beam_if beam_bus ();
	car_if car_bus ();

	// raster position
	beam_decoder beam_decoder_i (
		.dclk (dclk),
		.clr  (clr),
		.beam (beam_bus)
	);

	// animation step
	traffic_motion traffic_motion_i (
		.dclk      (dclk),
		.clr       (clr),
		.anim_tick (anim_tick),
		.light     (light),
		.cars      (car_bus)
	);

	collision_detector collision_detector_i (
		.dclk (dclk),
		.clr  (clr),
		.cars (car_bus)
	);

	// result pixel
	pixel_compositor pixel_compositor_i (
		.dclk  (dclk),
		.clr   (clr),
		.light (light),
		.beam  (beam_bus),
		.cars  (car_bus),
		.hsync (hsync),
		.vsync (vsync),
		.rgb   (pix_rgb)
	);

	// split 3-3-2 colour onto the dac pins
	assign red       = pix_rgb[7:5];
	assign green     = pix_rgb[4:2];
	assign blue      = pix_rgb[1:0];
	assign game_over = car_bus.crashed;

endmodule

// File: hw/pixel_compositor.sv
module pixel_compositor (
	input  logic            dclk,
	input  logic            clr,
	input  logic [3:0]      light,
	beam_if.sink            beam,
	car_if.viewer           cars,
	output logic            hsync,
	output logic            vsync,
	output scene_pkg::rgb_t rgb
);

	// colour of the current beam position before the output register
	scene_pkg::rgb_t pix;
	// beam inside the horizontal / vertical road band
	logic in_row;
	logic in_col;

	// ------------------------------------------------------------------------
	// layering, lowest priority first so later layers overwrite
	// ------------------------------------------------------------------------
	always_comb
	begin
		in_row = (beam.py >= scene_pkg::ROAD_Y0) && (beam.py < scene_pkg::ROAD_Y1);
		in_col = (beam.px >= scene_pkg::ROAD_X0) && (beam.px < scene_pkg::ROAD_X1);

		// grass
		pix = scene_pkg::GREEN;

		// roads, centre square included
		if (in_row || in_col)
			pix = scene_pkg::BLACK;

		// cars, walked backwards so car 0 ends on top
		for (int i = scene_pkg::NUM_CARS - 1; i >= 0; i--)
		begin
			if (scene_pkg::in_rect(beam.px, beam.py,
				scene_pkg::car_x(i, cars.offset[i]), scene_pkg::car_y(i, cars.offset[i]),
				scene_pkg::car_w(i), scene_pkg::car_h(i)))
				pix = scene_pkg::CAR_COLOUR[i];
		end

		// light housings
		for (int i = 0; i < 4; i++)
		begin
			if (scene_pkg::in_rect(beam.px, beam.py, scene_pkg::BOX_X[i], scene_pkg::BOX_Y[i],
				scene_pkg::BOX_W[i], scene_pkg::BOX_H[i]))
				pix = scene_pkg::YELLOW;
		end

		// green lamps, lit when the bit is 1
		for (int i = 0; i < 4; i++)
		begin
			if (scene_pkg::in_rect(beam.px, beam.py, scene_pkg::GRN_LAMP_X[i],
				scene_pkg::GRN_LAMP_Y[i], scene_pkg::LAMP_SIZE, scene_pkg::LAMP_SIZE))
				pix = light[i] ? scene_pkg::GREEN : scene_pkg::BLACK;
		end

		// red lamps on top, lit when the bit is 0
		for (int i = 0; i < 4; i++)
		begin
			if (scene_pkg::in_rect(beam.px, beam.py, scene_pkg::RED_LAMP_X[i],
				scene_pkg::RED_LAMP_Y[i], scene_pkg::LAMP_SIZE, scene_pkg::LAMP_SIZE))
				pix = light[i] ? scene_pkg::BLACK : scene_pkg::RED;
		end

		// blanking
		if (!beam.active)
			pix = scene_pkg::BLACK;
	end

	// ------------------------------------------------------------------------
	// output register
	// ------------------------------------------------------------------------
	// colour and both syncs share one stage so they stay aligned
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			rgb   <= scene_pkg::BLACK;
		end
		else
		begin
			hsync <= beam.hsync_n;
			vsync <= beam.vsync_n;
			rgb   <= pix;
		end
	end

endmodule

// File: hw/scene_ifs.sv
// raster position from the beam decoder to the compositor
interface beam_if;

	// raw sync levels, low during the pulse
	logic hsync_n;
	logic vsync_n;
	// inside the 640x480 window
	logic active;
	// position relative to the back porches
	vga_timing_pkg::coord_t px;
	vga_timing_pkg::coord_t py;

	modport source (output hsync_n, output vsync_n, output active, output px, output py);
	modport sink (input hsync_n, input vsync_n, input active, input px, input py);

endinterface

// car state shared by motion, collision and drawing
interface car_if;

	// moving coordinate of each car
	vga_timing_pkg::coord_t offset [scene_pkg::NUM_CARS];
	// sticky, freezes the motion
	logic crashed;

	// motion updates offsets and obeys the crash flag
	modport motion (output offset, input crashed);
	// detector watches offsets and raises the flag
	modport detector (input offset, output crashed);
	// compositor only draws
	modport viewer (input offset);

endinterface

// File: hw/scene_pkg.sv
package scene_pkg;

	// colour packed r3 g3 b2
	typedef logic [7:0] rgb_t;

	localparam rgb_t BLACK  = 8'b000_000_00;
	localparam rgb_t WHITE  = 8'b111_111_11;
	localparam rgb_t YELLOW = 8'b111_111_00;
	localparam rgb_t CYAN   = 8'b000_111_11;
	localparam rgb_t GREEN  = 8'b000_111_00;
	localparam rgb_t RED    = 8'b111_000_00;
	localparam rgb_t BLUE   = 8'b000_000_11;

	// travel direction of a car
	typedef enum logic [1:0] {
		DIR_NORTH,
		DIR_EAST,
		DIR_SOUTH,
		DIR_WEST
	} dir_t;

	// ------------------------------------------------------------------------
	// car geometry and table
	// ------------------------------------------------------------------------
	// size along the travel direction
	localparam vga_timing_pkg::coord_t CAR_LONG  = 10'd60;
	// size across it
	localparam vga_timing_pkg::coord_t CAR_SHORT = 10'd30;

	localparam int NUM_CARS = 4;

	// offset where a car waits while its light is red
	localparam vga_timing_pkg::coord_t STOP_EAST  = 10'd140;
	localparam vga_timing_pkg::coord_t STOP_SOUTH = 10'd60;

	// two eastbound lanes, two southbound lanes
	localparam dir_t CAR_DIR [NUM_CARS] = '{DIR_EAST, DIR_EAST, DIR_SOUTH, DIR_SOUTH};
	// y for eastbound, x for southbound
	localparam vga_timing_pkg::coord_t CAR_FIXED [NUM_CARS] = '{10'd315, 10'd255,
		10'd275, 10'd215};
	// pixels per tick
	localparam logic [1:0] CAR_SPEED [NUM_CARS] = '{2'd1, 2'd2, 2'd1, 2'd2};
	localparam rgb_t CAR_COLOUR [NUM_CARS] = '{BLUE, CYAN, YELLOW, GREEN};
	// which light bit governs the car
	localparam logic [1:0] CAR_LIGHT [NUM_CARS] = '{2'd1, 2'd1, 2'd2, 2'd2};

	// ------------------------------------------------------------------------
	// static scenery, screen coordinates
	// ------------------------------------------------------------------------
	// lamp n belongs to light bit n
	localparam vga_timing_pkg::coord_t LAMP_SIZE = 10'd15;
	localparam vga_timing_pkg::coord_t RED_LAMP_X [4] = '{10'd363, 10'd615, 10'd262, 10'd5};
	localparam vga_timing_pkg::coord_t RED_LAMP_Y [4] = '{10'd5, 10'd283, 10'd460, 10'd182};
	localparam vga_timing_pkg::coord_t GRN_LAMP_X [4] = '{10'd382, 10'd615, 10'd243, 10'd5};
	localparam vga_timing_pkg::coord_t GRN_LAMP_Y [4] = '{10'd5, 10'd302, 10'd460, 10'd163};

	// yellow housings behind the lamps
	localparam vga_timing_pkg::coord_t BOX_X [4] = '{10'd0, 10'd610, 10'd360, 10'd240};
	localparam vga_timing_pkg::coord_t BOX_Y [4] = '{10'd160, 10'd280, 10'd0, 10'd455};
	localparam vga_timing_pkg::coord_t BOX_W [4] = '{10'd25, 10'd25, 10'd40, 10'd40};
	localparam vga_timing_pkg::coord_t BOX_H [4] = '{10'd40, 10'd40, 10'd25, 10'd25};

	// road bands, upper bound exclusive
	// their crossing is the centre square
	localparam vga_timing_pkg::coord_t ROAD_X0 = 10'd200;
	localparam vga_timing_pkg::coord_t ROAD_X1 = 10'd440;
	localparam vga_timing_pkg::coord_t ROAD_Y0 = 10'd120;
	localparam vga_timing_pkg::coord_t ROAD_Y1 = 10'd360;

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	// east and west cars move along x
	function automatic logic along_x(input dir_t d);
		return (d == DIR_EAST) || (d == DIR_WEST);
	endfunction

	function automatic vga_timing_pkg::coord_t stop_offset(input dir_t d);
		return along_x(d) ? STOP_EAST : STOP_SOUTH;
	endfunction

	// moving coordinate equals the offset
	function automatic vga_timing_pkg::coord_t car_x(input int idx,
		input vga_timing_pkg::coord_t offset);
		return along_x(CAR_DIR[idx]) ? offset : CAR_FIXED[idx];
	endfunction

	function automatic vga_timing_pkg::coord_t car_y(input int idx,
		input vga_timing_pkg::coord_t offset);
		return along_x(CAR_DIR[idx]) ? CAR_FIXED[idx] : offset;
	endfunction

	function automatic vga_timing_pkg::coord_t car_w(input int idx);
		return along_x(CAR_DIR[idx]) ? CAR_LONG : CAR_SHORT;
	endfunction

	function automatic vga_timing_pkg::coord_t car_h(input int idx);
		return along_x(CAR_DIR[idx]) ? CAR_SHORT : CAR_LONG;
	endfunction

	// half-open box test, 11 bit sums so a car past 1023 does not wrap
	function automatic logic in_rect(
		input vga_timing_pkg::coord_t px,
		input vga_timing_pkg::coord_t py,
		input vga_timing_pkg::coord_t x,
		input vga_timing_pkg::coord_t y,
		input vga_timing_pkg::coord_t w,
		input vga_timing_pkg::coord_t h
	);
		logic in_x;
		logic in_y;
		in_x = ({1'b0, px} >= {1'b0, x}) && ({1'b0, px} < ({1'b0, x} + {1'b0, w}));
		in_y = ({1'b0, py} >= {1'b0, y}) && ({1'b0, py} < ({1'b0, y} + {1'b0, h}));
		return in_x && in_y;
	endfunction

endpackage

// File: hw/traffic_motion.sv
module traffic_motion (
	input  logic       dclk,
	input  logic       clr,
	input  logic       anim_tick,
	input  logic [3:0] light,
	car_if.motion      cars
);

	// previous sample of the tick level
	logic tick_q;
	// one dclk strobe per tick
	logic tick_rise;
	// car waiting at its stop line
	logic [scene_pkg::NUM_CARS-1:0] hold;

	// ------------------------------------------------------------------------
	// tick edge detect
	// ------------------------------------------------------------------------
	// starts high so a tick already high at reset release is not an edge
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
			tick_q <= 1'b1;
		else
			tick_q <= anim_tick;
	end

	assign tick_rise = anim_tick && !tick_q;

	// ------------------------------------------------------------------------
	// stop-line rule
	// ------------------------------------------------------------------------
	always_comb
	begin
		for (int i = 0; i < scene_pkg::NUM_CARS; i++)
		begin
			// light bit 0 means red
			hold[i] = !light[scene_pkg::CAR_LIGHT[i]] &&
				(cars.offset[i] == scene_pkg::stop_offset(scene_pkg::CAR_DIR[i]));
		end
	end

	// ------------------------------------------------------------------------
	// offset advance
	// ------------------------------------------------------------------------
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			for (int i = 0; i < scene_pkg::NUM_CARS; i++)
				cars.offset[i] <= '0;
		end
		else if (tick_rise && !cars.crashed)
		begin
			for (int i = 0; i < scene_pkg::NUM_CARS; i++)
			begin
				// wraps at 1024, car reappears from the edge
				if (!hold[i])
					cars.offset[i] <= cars.offset[i] +
						vga_timing_pkg::coord_t'(scene_pkg::CAR_SPEED[i]);
			end
		end
	end

endmodule

// File: hw/vga_timing_pkg.sv
package vga_timing_pkg;

	// raster and screen coordinates share one width
	// 10 bits reaches 800 clocks and 521 lines
	typedef logic [9:0] coord_t;

	// ------------------------------------------------------------------------
	// totals for 640x480 at a 25 MHz pixel clock
	// ------------------------------------------------------------------------
	localparam coord_t H_TOTAL = 10'd800;
	localparam coord_t V_TOTAL = 10'd521;

	// sync pulses, active low from the start of line / frame
	localparam coord_t H_PULSE = 10'd96;
	localparam coord_t V_PULSE = 10'd2;

	// ------------------------------------------------------------------------
	// active window edges in raster counts
	// ------------------------------------------------------------------------
	// first visible clock of a line
	localparam coord_t H_BP = 10'd144;
	// first blanked clock after the visible part
	localparam coord_t H_FP = 10'd784;
	// first visible line
	localparam coord_t V_BP = 10'd31;
	// first blanked line after the visible part
	localparam coord_t V_FP = 10'd511;

	// visible size is 784-144 = 640 by 511-31 = 480

endpackage

// File: tb.f
hw/vga_timing_pkg.sv
hw/scene_pkg.sv
hw/scene_ifs.sv
hw/beam_decoder.sv
hw/traffic_motion.sv
hw/collision_detector.sv
hw/pixel_compositor.sv
hw/intersection_top.sv
verification/scene_model.sv
verification/intersection_tb.sv

// File: verification/intersection_tb.sv
module intersection_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 100;
	// 800 clocks by 521 lines
	localparam int FRAME = 416800;
	// each pixel batch needs at most two frames
	// the sync check needs about two more
	localparam int BATCHES = 8;
	localparam int WATCHDOG_CYCLES = (2 + 2 * BATCHES) * FRAME + 50000;

	logic       dclk;
	logic       clr;
	logic       anim_tick;
	logic [3:0] light;
	logic       hsync;
	logic       vsync;
	logic [2:0] red;
	logic [2:0] green;
	logic [1:0] blue;
	logic       game_over;

	// posedges since reset release
	// beam sits at cyc and the registered output shows cyc - 1
	int cyc;
	logic [31:0] lfsr_q = 32'h04053438;
	int errors;
	int checks;
	int tests;
	int errors_at_start;
	string test_name;
	// reference state of the cars
	int model_off [4];
	bit model_crash;
	// raster indices to sample and the colours seen there
	int pts [$];
	scene_pkg::rgb_t seen [$];

	intersection_top dut_i (
		.dclk      (dclk),
		.clr       (clr),
		.anim_tick (anim_tick),
		.light     (light),
		.hsync     (hsync),
		.vsync     (vsync),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.game_over (game_over)
	);

	always #(CLK_PERIOD / 2) dclk = ~dclk;

	always @(posedge dclk or posedge clr)
	begin
		if (clr)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	// ------------------------------------------------------------------------
	// random bits from a Fibonacci LFSR with taps 32 22 2 1
	// ------------------------------------------------------------------------
	function automatic logic next_bit();
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(next_bit());
		return v;
	endfunction

	// ------------------------------------------------------------------------
	// checks and reporting
	// ------------------------------------------------------------------------
	task automatic check_value(input string what, input int expected, input int actual);
		checks++;
		assert (expected == actual)
		else
		begin
			$display("FAIL %s %s expected %0h actual %0h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string msg);
		checks++;
		assert (cond)
		else
		begin
			$display("ERROR %s: %s", test_name, msg);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		tests++;
		if (errors == errors_at_start)
			$display("test %s: ok", test_name);
		else
			$display("test %s: %0d errors", test_name, errors - errors_at_start);
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	// clr high for 8 cycles
	// returns between edges with the outputs at reset values
	task automatic apply_reset();
		@(posedge dclk);
		clr <= 1'b1;
		anim_tick <= 1'b0;
		repeat (8) @(posedge dclk);
		clr <= 1'b0;
		for (int i = 0; i < 4; i++)
			model_off[i] = 0;
		model_crash = 1'b0;
		@(negedge dclk);
	endtask

	// extra edge so the next registered pixel already sees the new lights
	task automatic set_light(input logic [3:0] value);
		@(posedge dclk);
		light <= value;
		@(posedge dclk);
	endtask

	// one tick
	// game_over checked on both cycles after the step
	task automatic issue_tick();
		bit was_crashed;
		was_crashed = model_crash;
		@(posedge dclk);
		anim_tick <= 1'b1;
		@(posedge dclk);
		anim_tick <= 1'b0;
		// DUT steps at this edge
		if (!model_crash)
		begin
			for (int i = 0; i < 4; i++)
				model_off[i] = scene_model::next_offset(i, model_off[i], light);
			model_crash = scene_model::overlap(model_off);
		end
		@(negedge dclk);
		check_value("game_over early", int'(was_crashed), int'(game_over));
		@(negedge dclk);
		check_value("game_over", int'(model_crash), int'(game_over));
	endtask

	// queue a visible point as a raster index
	// back porches are 144 and 31
	task automatic add_point(input int x, input int y);
		if (x >= 0 && x < 640 && y >= 0 && y < 480)
			pts.push_back((y + 31) * 800 + x + 144);
	endtask

	// corners inside and points just outside each car
	task automatic add_car_points();
		int x;
		int y;
		int w;
		int h;
		for (int i = 0; i < 4; i++)
		begin
			scene_model::car_rect(i, model_off[i], x, y, w, h);
			add_point(x, y);
			add_point(x + w - 1, y + h - 1);
			add_point(x - 1, y);
			add_point(x + w, y);
			add_point(x, y - 1);
			add_point(x, y + h);
		end
	endtask

	// walk the queued points in raster order
	// mostly within one frame
	task automatic sample_points();
		int last;
		int x;
		int y;
		scene_pkg::rgb_t exp_rgb;
		scene_pkg::rgb_t got;
		pts.sort();
		seen.delete();
		last = -1;
		foreach (pts[n])
		begin
			if (pts[n] == last)
				continue;
			last = pts[n];
			do
				@(negedge dclk);
			while (((cyc - 1) % FRAME) != pts[n]);
			x = pts[n] % 800 - 144;
			y = pts[n] / 800 - 31;
			got = {red, green, blue};
			seen.push_back(got);
			exp_rgb = scene_model::expect_pixel(x, y, light, model_off);
			check_value($sformatf("pixel (%0d,%0d)", x, y), int'(exp_rgb), int'(got));
		end
		pts.delete();
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic test_sync();
		logic [1:0] prev;
		logic [1:0] cur;
		int falls [2];
		int t0 [2];
		int period [2];
		int low [2];
		start_test("reset and sync");
		apply_reset();
		check_value("hsync", 1, int'(hsync));
		check_value("vsync", 1, int'(vsync));
		check_value("game_over", 0, int'(game_over));
		prev = 2'b11;
		// bit 0 is hsync and bit 1 is vsync
		// measured from the first falling edge
		while (falls[0] < 2 || falls[1] < 2)
		begin
			@(negedge dclk);
			cur = {vsync, hsync};
			for (int s = 0; s < 2; s++)
			begin
				if (prev[s] && !cur[s])
				begin
					if (falls[s] == 1)
						period[s] = cyc - t0[s];
					t0[s] = cyc;
					falls[s]++;
				end
				if (falls[s] == 1 && !cur[s])
					low[s]++;
			end
			prev = cur;
		end
		check_value("hsync period", 800, period[0]);
		check_value("hsync low", 96, low[0]);
		check_value("vsync period", FRAME, period[1]);
		check_value("vsync low", 2 * 800, low[1]);
		end_test();
	endtask

	task automatic test_static();
		int x;
		int y;
		int k;
		start_test("static scene");
		for (int round = 0; round < 2; round++)
		begin
			set_light(4'(rand_bits(4)));
			while (pts.size() < 10)
			begin
				k = rand_bits(3);
				if (pts.size() % 2 == 0)
				begin
					// inside a lamp
					// red ones for k below 4
					x = ((k < 4) ? scene_model::RED_X[k % 4] : scene_model::GRN_X[k % 4]) +
						rand_bits(4) % 15;
					y = ((k < 4) ? scene_model::RED_Y[k % 4] : scene_model::GRN_Y[k % 4]) +
						rand_bits(4) % 15;
				end
				else
				begin
					x = rand_bits(10) % 640;
					y = rand_bits(9) % 480;
				end
				// keep clear of the parked cars
				if (scene_model::car_at(x, y, model_off) < 0)
					add_point(x, y);
			end
			sample_points();
		end
		end_test();
	endtask

	task automatic test_red_stop();
		int want [4];
		start_test("red stop");
		apply_reset();
		set_light(4'b0000);
		repeat (100) issue_tick();
		want = '{100, 140, 60, 60};
		for (int i = 0; i < 4; i++)
			check_value($sformatf("model offset %0d", i), want[i], model_off[i]);
		add_car_points();
		sample_points();
		check_value("game_over", 0, int'(game_over));
		end_test();
	endtask

	task automatic test_one_way();
		start_test("one-way green");
		apply_reset();
		// light 1 green and light 2 red with the others random
		set_light((4'(rand_bits(4)) | 4'b0010) & 4'b1011);
		for (int round = 0; round < 2; round++)
		begin
			repeat (150 + rand_bits(7)) issue_tick();
			check_value("south car 2 held", 60, model_off[2]);
			check_value("south car 3 held", 60, model_off[3]);
			add_car_points();
			sample_points();
		end
		end_test();
	endtask

	task automatic test_crash();
		int n;
		scene_pkg::rgb_t prior [$];
		start_test("crash and freeze");
		apply_reset();
		set_light(4'(rand_bits(4)) | 4'b0110);
		n = 0;
		while (!model_crash && n < 600)
		begin
			issue_tick();
			n++;
		end
		check_true(model_crash, "no crossing overlap predicted within 600 ticks");
		add_car_points();
		sample_points();
		prior = seen;
		// motion is frozen now
		repeat (5) issue_tick();
		add_car_points();
		sample_points();
		foreach (seen[i])
		begin
			if (i < prior.size())
				check_value("frozen pixel", int'(prior[i]), int'(seen[i]));
		end
		apply_reset();
		check_value("game_over after reset", 0, int'(game_over));
		add_car_points();
		sample_points();
		end_test();
	endtask

	// ------------------------------------------------------------------------
	// main sequence and watchdog
	// ------------------------------------------------------------------------
	initial
	begin
		dclk = 1'b0;
		clr = 1'b1;
		anim_tick = 1'b0;
		light = 4'b0000;
		test_sync();
		test_static();
		test_red_stop();
		test_one_way();
		test_crash();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: verification/scene_model.sv
package scene_model;

	// cars 0 and 1 run east and cars 2 and 3 run south
	localparam int FIXED [4] = '{315, 255, 275, 215};
	localparam int SPEED [4] = '{1, 2, 1, 2};
	localparam int LIGHT_BIT [4] = '{1, 1, 2, 2};
	localparam scene_pkg::rgb_t COLOUR [4] = '{scene_pkg::BLUE, scene_pkg::CYAN,
		scene_pkg::YELLOW, scene_pkg::GREEN};

	// ------------------------------------------------------------------------
	// static scenery
	// ------------------------------------------------------------------------
	// lamp k follows light bit k
	localparam int RED_X [4] = '{363, 615, 262, 5};
	localparam int RED_Y [4] = '{5, 283, 460, 182};
	localparam int GRN_X [4] = '{382, 615, 243, 5};
	localparam int GRN_Y [4] = '{5, 302, 460, 163};
	localparam int BOX_X [4] = '{0, 610, 360, 240};
	localparam int BOX_Y [4] = '{160, 280, 0, 455};
	localparam int BOX_W [4] = '{25, 25, 40, 40};
	localparam int BOX_H [4] = '{40, 40, 25, 25};

	// rectangle of car i at a given offset
	function automatic void car_rect(input int i, input int off,
		output int x, output int y, output int w, output int h);
		x = (i < 2) ? off : FIXED[i];
		y = (i < 2) ? FIXED[i] : off;
		w = (i < 2) ? 60 : 30;
		h = (i < 2) ? 30 : 60;
	endfunction

	// offset after one tick
	// a car waits at its stop line while its light is red
	function automatic int next_offset(input int i, input int off, input logic [3:0] light);
		if (!light[LIGHT_BIT[i]] && off == ((i < 2) ? 140 : 60))
			return off;
		return (off + SPEED[i]) % 1024;
	endfunction

	function automatic bit in_box(input int x, input int y, input int x0, input int y0,
		input int w, input int h);
		return x >= x0 && x < x0 + w && y >= y0 && y < y0 + h;
	endfunction

	// crossing pairs only
	// touching edges count as a hit
	function automatic bit overlap(input int off [4]);
		int ax;
		int ay;
		int aw;
		int ah;
		int bx;
		int by;
		int bw;
		int bh;
		for (int i = 0; i < 2; i++)
			for (int j = 2; j < 4; j++)
			begin
				car_rect(i, off[i], ax, ay, aw, ah);
				car_rect(j, off[j], bx, by, bw, bh);
				if (ax <= bx + bw && bx <= ax + aw && ay <= by + bh && by <= ay + ah)
					return 1'b1;
			end
		return 1'b0;
	endfunction

	// lowest numbered car at a point
	// -1 when there is none
	function automatic int car_at(input int x, input int y, input int off [4]);
		int cx;
		int cy;
		int cw;
		int ch;
		for (int i = 0; i < 4; i++)
		begin
			car_rect(i, off[i], cx, cy, cw, ch);
			if (in_box(x, y, cx, cy, cw, ch))
				return i;
		end
		return -1;
	endfunction

	// expected colour of a visible point
	// highest layer first
	function automatic scene_pkg::rgb_t expect_pixel(input int x, input int y,
		input logic [3:0] light, input int off [4]);
		int c;
		c = car_at(x, y, off);
		for (int k = 0; k < 4; k++)
			if (in_box(x, y, RED_X[k], RED_Y[k], 15, 15))
				return light[k] ? scene_pkg::BLACK : scene_pkg::RED;
		for (int k = 0; k < 4; k++)
			if (in_box(x, y, GRN_X[k], GRN_Y[k], 15, 15))
				return light[k] ? scene_pkg::GREEN : scene_pkg::BLACK;
		for (int k = 0; k < 4; k++)
			if (in_box(x, y, BOX_X[k], BOX_Y[k], BOX_W[k], BOX_H[k]))
				return scene_pkg::YELLOW;
		if (c >= 0)
			return COLOUR[c];
		// centre square lies inside both road bands
		if ((x >= 200 && x < 440) || (y >= 120 && y < 360))
			return scene_pkg::BLACK;
		// grass
		return scene_pkg::GREEN;
	endfunction

endpackage
